// File: logic/riscv_pkg.sv
// Core widths and depths, opcode and funct codes, ALU ops, instruction formats, stage structs
package riscv_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths, depths, credits
    //////////////////////////////////////////////////////////////////////
    localparam int XLEN          = 32;                         // Data and address width
    localparam int REG_ADDR_W    = 5;                          // x0..x31
    localparam int FETCH_DEPTH   = 4;                          // Sender starts with this many credits
    localparam int FETCH_AW      = $clog2(FETCH_DEPTH);        // Buffer index width
    localparam int STORE_DEPTH   = 4;                          // Store queue entries
    localparam int STORE_AW      = $clog2(STORE_DEPTH);        // Queue index width
    localparam int STORE_CREDITS = 2;                          // Receiver slots
    localparam int CREDIT_W      = $clog2(STORE_CREDITS + 1);  // Holds 0..STORE_CREDITS

    // Opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Reg-reg ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Reg-imm ALU
    localparam logic [6:0] OPC_STORE  = 7'b0100011;  // SW is the only store kept

    // funct3 / funct7
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_SW   = 3'b010;  // Shares SLT's code under the store opcode
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // Instruction word, three field layouts
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm;     // Sign bit at [11]
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]            imm_hi;  // imm[11:5]
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;  // imm[4:0]
        logic [6:0]            opcode;
    } s_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
    } instr_u;

    //////////////////////////////////////////////////////////////////////
    // Stage-to-stage bundles
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic   valid;
        instr_u instr;
    } instr_in_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       op_a;        // rs1 value
        logic [XLEN-1:0]       op_b;        // rs2 value or immediate
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
        logic                  is_store;
        logic [XLEN-1:0]       store_data;  // rs2 value for SW
    } dec_op_t;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } rf_wr_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } store_t;

endpackage

// File: logic/instr_buffer.sv
// Instruction FIFO on the input side, returns one credit per word popped
`timescale 1ns/1ps

module instr_buffer (
    input  logic                 clk,
    input  logic                 arst_n,
    input  riscv_pkg::instr_in_t instr_in,
    input  logic                 take,          // Decode pops head
    output riscv_pkg::instr_in_t head,
    output logic                 instr_credit
);

    riscv_pkg::instr_u                mem [riscv_pkg::FETCH_DEPTH];  // Word storage
    logic [riscv_pkg::FETCH_AW:0]     wr_ptr;   // Extra MSB tells full from empty
    logic [riscv_pkg::FETCH_AW:0]     rd_ptr;
    logic                             empty;
    logic                             full;
    logic                             pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[riscv_pkg::FETCH_AW] != rd_ptr[riscv_pkg::FETCH_AW]) &&
                   (wr_ptr[riscv_pkg::FETCH_AW-1:0] == rd_ptr[riscv_pkg::FETCH_AW-1:0]);
    assign pop   = take && !empty;

    assign head.valid   = !empty;                                   // Word waiting
    assign head.instr   = mem[rd_ptr[riscv_pkg::FETCH_AW-1:0]];
    assign instr_credit = pop;                                      // Credit back same cycle

    // Write port
    always_ff @(posedge clk) begin
        if (instr_in.valid && !full) begin
            mem[wr_ptr[riscv_pkg::FETCH_AW-1:0]] <= instr_in.instr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (instr_in.valid && !full) wr_ptr <= wr_ptr + 1'b1;  // Sender never overruns
            if (pop)                     rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

// File: logic/decode_stage.sv
// Decode stage: instruction field decode, operand read with forwarding, decoded-op register
`timescale 1ns/1ps

module decode_stage (
    input  logic                             clk,
    input  logic                             arst_n,
    input  riscv_pkg::instr_in_t             head,
    output logic                             take,
    input  logic                             ready,     // Execute accepts next op
    output logic [riscv_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [riscv_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [riscv_pkg::XLEN-1:0]       rs1_data,
    input  logic [riscv_pkg::XLEN-1:0]       rs2_data,
    input  riscv_pkg::rf_wr_t                fwd,       // Execute's write this cycle
    output riscv_pkg::dec_op_t               dec_op
);

    riscv_pkg::instr_u          ins;
    logic [riscv_pkg::XLEN-1:0] src1;     // rs1 after forwarding
    logic [riscv_pkg::XLEN-1:0] src2;
    logic [riscv_pkg::XLEN-1:0] imm_i;
    logic [riscv_pkg::XLEN-1:0] imm_s;
    logic                       alu_ok;   // funct3 is one we support
    riscv_pkg::dec_op_t         nxt;

    assign ins      = head.instr;
    assign take     = head.valid && ready;
    assign rs1_addr = ins.r.rs1;          // Same bits in all three formats
    assign rs2_addr = ins.r.rs2;

    // Bypass execute's write that is not yet in the file
    assign src1 = (fwd.en && fwd.addr != '0 && fwd.addr == rs1_addr) ? fwd.data : rs1_data;
    assign src2 = (fwd.en && fwd.addr != '0 && fwd.addr == rs2_addr) ? fwd.data : rs2_data;

    assign imm_i = {{(riscv_pkg::XLEN-12){ins.i.imm[11]}}, ins.i.imm};
    assign imm_s = {{(riscv_pkg::XLEN-12){ins.s.imm_hi[6]}}, ins.s.imm_hi, ins.s.imm_lo};

    always_comb begin
        nxt            = '0;
        nxt.valid      = head.valid;
        nxt.op_a       = src1;
        nxt.op_b       = src2;
        nxt.rd         = ins.r.rd;
        nxt.store_data = src2;
        nxt.alu_op     = riscv_pkg::ALU_ADD;
        alu_ok         = 1'b1;
        case (ins.r.funct3)
            riscv_pkg::F3_ADD:  nxt.alu_op = (ins.r.opcode == riscv_pkg::OPC_OP &&
                                              ins.r.funct7 == riscv_pkg::F7_SUB) ?
                                             riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
            riscv_pkg::F3_SLT:  nxt.alu_op = riscv_pkg::ALU_SLT;
            riscv_pkg::F3_SLTU: nxt.alu_op = riscv_pkg::ALU_SLTU;
            riscv_pkg::F3_XOR:  nxt.alu_op = riscv_pkg::ALU_XOR;
            riscv_pkg::F3_OR:   nxt.alu_op = riscv_pkg::ALU_OR;
            riscv_pkg::F3_AND:  nxt.alu_op = riscv_pkg::ALU_AND;
            default:            alu_ok     = 1'b0;  // Shifts are not kept
        endcase
        case (ins.r.opcode)
            riscv_pkg::OPC_OP:     nxt.rd_we = alu_ok;
            riscv_pkg::OPC_OP_IMM: begin
                nxt.op_b  = imm_i;
                nxt.rd_we = alu_ok;
            end
            riscv_pkg::OPC_STORE:  begin
                nxt.op_b     = imm_s;                  // Address = rs1 + imm
                nxt.alu_op   = riscv_pkg::ALU_ADD;
                nxt.is_store = (ins.s.funct3 == riscv_pkg::F3_SW);
            end
            default: ;                                 // Retires as a no-op
        endcase
    end

    // Hold while execute is stalled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_op <= '0;
        end else if (ready) begin
            dec_op <= nxt;
        end
    end

endmodule

// File: logic/reg_file.sv
// 32-entry integer register file, x0 fixed at zero, two combinational read ports
`timescale 1ns/1ps

module reg_file (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [riscv_pkg::XLEN-1:0]       rs1_data,
    output logic [riscv_pkg::XLEN-1:0]       rs2_data,
    input  riscv_pkg::rf_wr_t                wr        // From execute
);

    logic [riscv_pkg::XLEN-1:0] regs [1:31];  // Storage for x1..x31 only

    // All registers start at zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.addr != '0) begin  // x0 writes dropped
            regs[wr.addr] <= wr.data;
        end
    end

    // Pending write shows up only after the next edge
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: logic/exec_stage.sv
// Execute stage: ALU, store address, register write and store hand-off to the queue
`timescale 1ns/1ps

module exec_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  riscv_pkg::dec_op_t dec_op,
    output logic               ready,    // Low only for a blocked store
    output riscv_pkg::rf_wr_t  wr,
    output riscv_pkg::store_t  push,
    input  logic               sq_full
);

    logic [riscv_pkg::XLEN-1:0] result;
    logic                       blocked;  // Store with no room in queue

    always_comb begin
        case (dec_op.alu_op)
            riscv_pkg::ALU_SUB:  result = dec_op.op_a - dec_op.op_b;
            riscv_pkg::ALU_AND:  result = dec_op.op_a & dec_op.op_b;
            riscv_pkg::ALU_OR:   result = dec_op.op_a | dec_op.op_b;
            riscv_pkg::ALU_XOR:  result = dec_op.op_a ^ dec_op.op_b;
            riscv_pkg::ALU_SLT:  result = {{(riscv_pkg::XLEN-1){1'b0}},
                                           $signed(dec_op.op_a) < $signed(dec_op.op_b)};
            riscv_pkg::ALU_SLTU: result = {{(riscv_pkg::XLEN-1){1'b0}},
                                           dec_op.op_a < dec_op.op_b};
            default:             result = dec_op.op_a + dec_op.op_b;  // ADD and store address
        endcase
    end

    assign blocked = dec_op.valid && dec_op.is_store && sq_full;
    assign ready   = !blocked;

    assign wr.en   = dec_op.valid && dec_op.rd_we && ready;
    assign wr.addr = dec_op.rd;
    assign wr.data = result;

    assign push.valid = dec_op.valid && dec_op.is_store && !sq_full;
    assign push.addr  = result;
    assign push.data  = dec_op.store_data;

endmodule

// File: logic/store_queue.sv
// Store FIFO on the output side with a credit counter toward the receiver
`timescale 1ns/1ps

module store_queue (
    input  logic              clk,
    input  logic              arst_n,
    input  riscv_pkg::store_t push,
    output logic              sq_full,
    output riscv_pkg::store_t store_out,
    input  logic              data_credit   // One slot freed downstream
);

    logic [riscv_pkg::XLEN-1:0]     addr_mem [riscv_pkg::STORE_DEPTH];
    logic [riscv_pkg::XLEN-1:0]     data_mem [riscv_pkg::STORE_DEPTH];
    logic [riscv_pkg::STORE_AW:0]   wr_ptr;      // Extra MSB for wrap
    logic [riscv_pkg::STORE_AW:0]   rd_ptr;
    logic                           empty;
    logic                           pop;
    logic [riscv_pkg::CREDIT_W-1:0] credit_cnt;  // Free receiver slots

    assign empty   = (wr_ptr == rd_ptr);
    assign sq_full = (wr_ptr[riscv_pkg::STORE_AW] != rd_ptr[riscv_pkg::STORE_AW]) &&
                     (wr_ptr[riscv_pkg::STORE_AW-1:0] == rd_ptr[riscv_pkg::STORE_AW-1:0]);
    assign pop     = !empty && (credit_cnt != '0);  // Send only with a credit

    assign store_out.valid = pop;
    assign store_out.addr  = addr_mem[rd_ptr[riscv_pkg::STORE_AW-1:0]];
    assign store_out.data  = data_mem[rd_ptr[riscv_pkg::STORE_AW-1:0]];

    always_ff @(posedge clk) begin
        if (push.valid && !sq_full) begin
            addr_mem[wr_ptr[riscv_pkg::STORE_AW-1:0]] <= push.addr;
            data_mem[wr_ptr[riscv_pkg::STORE_AW-1:0]] <= push.data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and credits
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            credit_cnt <= riscv_pkg::STORE_CREDITS[riscv_pkg::CREDIT_W-1:0];  // All slots free
        end else begin
            if (push.valid && !sq_full) wr_ptr <= wr_ptr + 1'b1;
            if (pop)                    rd_ptr <= rd_ptr + 1'b1;
            case ({pop, data_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;  // Spent one
                2'b01:   credit_cnt <= credit_cnt + 1'b1;  // Got one back
                default: ;                                 // Both or neither cancel out
            endcase
        end
    end

endmodule

// File: logic/riscv_core.sv
// RV32I subset core top: instruction buffer, decode, register file, execute and store queue
`timescale 1ns/1ps

module riscv_core (
    input  logic                clk,
    input  logic                arst_n,
    input  riscv_pkg::instr_in_t instr_in,     // Credit-based instruction stream
    output logic                instr_credit,  // One pulse per word handed to decode
    output riscv_pkg::store_t   store_out,     // One valid cycle per store
    input  logic                data_credit    // Receiver freed a slot
);

    riscv_pkg::instr_in_t           head;      // Buffer head toward decode
    logic                           take;
    logic                           ready;     // Execute can accept
    logic [riscv_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [riscv_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [riscv_pkg::XLEN-1:0]     rs1_data;
    logic [riscv_pkg::XLEN-1:0]     rs2_data;
    riscv_pkg::dec_op_t             dec_op;
    riscv_pkg::rf_wr_t              rf_wr;     // Also the forward path
    riscv_pkg::store_t              push;
    logic                           sq_full;

    instr_buffer instr_buffer (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_in     (instr_in),
        .take         (take),
        .head         (head),
        .instr_credit (instr_credit)
    );

    decode_stage decode_stage (
        .clk      (clk),
        .arst_n   (arst_n),
        .head     (head),
        .take     (take),
        .ready    (ready),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .fwd      (rf_wr),
        .dec_op   (dec_op)
    );

    reg_file reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr       (rf_wr)
    );

    exec_stage exec_stage (
        .clk     (clk),
        .arst_n  (arst_n),
        .dec_op  (dec_op),
        .ready   (ready),
        .wr      (rf_wr),
        .push    (push),
        .sq_full (sq_full)
    );

    store_queue store_queue (
        .clk         (clk),
        .arst_n      (arst_n),
        .push        (push),
        .sq_full     (sq_full),
        .store_out   (store_out),
        .data_credit (data_credit)
    );

endmodule

// File: dv/riscv_core_asserts.sv
// Concurrent checks on store credits, buffer overrun and reset outputs, bound into riscv_core
`timescale 1ns/1ps

module riscv_core_asserts (
    input logic                           clk,
    input logic                           arst_n,
    input logic                           instr_credit,
    input logic                           store_valid,
    input logic                           data_credit,  // Receiver frees a slot
    input logic [riscv_pkg::CREDIT_W-1:0] credit_cnt,   // Store queue credit counter
    input logic                           buf_full,     // Instruction buffer full
    input logic                           instr_valid   // Sender pushes a word
);

    localparam logic [riscv_pkg::CREDIT_W-1:0] MAX_CREDITS =
        riscv_pkg::STORE_CREDITS[riscv_pkg::CREDIT_W-1:0];

    logic [riscv_pkg::CREDIT_W-1:0] outstanding;  // Stores sent and not yet freed

    // Receiver occupancy as seen at the core's pins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= '0;
        end else begin
            case ({store_valid, data_credit})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: ;
            endcase
        end
    end

    // A store leaves only while the receiver has a free slot
    a_store_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        store_valid |-> outstanding < MAX_CREDITS)
        else $error("store_out.valid with zero store credits");

    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credit_cnt <= MAX_CREDITS)
        else $error("store credit count above receiver slots");

    // Checked only while reset is low
    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !instr_credit && !store_valid)
        else $error("instr_credit or store_out.valid high in reset");

    a_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
        buf_full |-> !instr_valid)
        else $error("instruction word sent while buffer full");

endmodule

bind riscv_core riscv_core_asserts asserts (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_credit (instr_credit),
    .store_valid  (store_out.valid),
    .data_credit  (data_credit),
    .credit_cnt   (store_queue.credit_cnt),
    .buf_full     (instr_buffer.full),
    .instr_valid  (instr_in.valid)
);

// File: dv/riscv_core_tb.sv
// Testbench for riscv_core: clock, reset, LCG program generator, reference model, receiver, report
`timescale 1ns/1ps

module riscv_core_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int N_RAND      = 160;                    // Random ALU and SW words
    localparam int N_X0        = 24;
    localparam int N_CHAIN     = 24;
    localparam int N_BP        = 24;
    localparam int N_BAD       = 40;
    localparam int N_DUMP      = 32;                     // One SW per register
    localparam int HOLD_CYCLES = 60;                     // Receiver silent this long
    localparam int TOTAL_WORDS = N_RAND + N_X0 + 2 * N_CHAIN + N_BP + N_BAD + 5 * N_DUMP;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 24 + HOLD_CYCLES + 200;

    logic                 clk;
    logic                 arst_n;
    riscv_pkg::instr_in_t instr_in;
    logic                 instr_credit;
    riscv_pkg::store_t    store_out;
    logic                 data_credit;

    logic [31:0] seed;
    logic [31:0] model_regs [32];       // Architectural state with x0 never written
    logic [63:0] exp_q [$];             // {addr, data} in program order
    logic [31:0] tx_q [$];              // Words waiting for a sender credit
    int          tx_credits;            // Sender side
    int          held;                  // Stores the receiver has not freed
    int          rx_count;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_errs0;            // Error count when the test began
    logic        burst;                 // Send on every credit
    logic        hold_credits;          // Receiver keeps its slots

    riscv_core uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_in     (instr_in),
        .instr_credit (instr_credit),
        .store_out    (store_out),
        .data_credit  (data_credit)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Random numbers and instruction encoding
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Upper bits since low LCG bits repeat quickly
    function automatic int unsigned rand_below(input int unsigned n);
        return (next_rand() >> 8) % n;
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(rand_below(8));                         // Eight regs for frequent hazards
    endfunction

    function automatic logic [2:0] pick_f3(input int unsigned k);
        case (k)
            0:       return riscv_pkg::F3_ADD;
            1:       return riscv_pkg::F3_SLT;
            2:       return riscv_pkg::F3_SLTU;
            3:       return riscv_pkg::F3_XOR;
            4:       return riscv_pkg::F3_OR;
            default: return riscv_pkg::F3_AND;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, riscv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, riscv_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, riscv_pkg::F3_SW, imm[4:0], riscv_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] alu_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = pick_f3(rand_below(6));
        if (rand_below(2) == 1) begin
            f7 = (f3 == riscv_pkg::F3_ADD && rand_below(2) == 1) ? riscv_pkg::F7_SUB : 7'b0;
            return enc_r(f7, rs2, rs1, f3, rd);
        end
        return enc_i(12'(rand_below(4096)), rs1, f3, rd);
    endfunction

    function automatic logic [31:0] random_word();
        if (rand_below(5) == 0) begin
            return enc_s(12'(rand_below(4096)), rand_reg(), rand_reg());
        end
        return alu_word(rand_reg(), rand_reg(), rand_reg());
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic void model_apply(input logic [31:0] w);
        logic [6:0]  opc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] imm_s;
        logic        we;
        opc   = w[6:0];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        res   = '0;
        we    = 1'b0;
        if (opc == riscv_pkg::OPC_OP || opc == riscv_pkg::OPC_OP_IMM) begin
            if (opc == riscv_pkg::OPC_OP_IMM) b = {{20{w[31]}}, w[31:20]};
            we = 1'b1;
            case (w[14:12])
                riscv_pkg::F3_ADD:  res = (opc == riscv_pkg::OPC_OP &&
                                           w[31:25] == riscv_pkg::F7_SUB) ? a - b : a + b;
                riscv_pkg::F3_SLT:  res = {31'b0, $signed(a) < $signed(b)};
                riscv_pkg::F3_SLTU: res = {31'b0, a < b};
                riscv_pkg::F3_XOR:  res = a ^ b;
                riscv_pkg::F3_OR:   res = a | b;
                riscv_pkg::F3_AND:  res = a & b;
                default:            we  = 1'b0;           // Shifts unsupported
            endcase
        end else if (opc == riscv_pkg::OPC_STORE && w[14:12] == riscv_pkg::F3_SW) begin
            exp_q.push_back({a + imm_s, b});
        end
        if (we && w[11:7] != 5'd0) model_regs[w[11:7]] = res;
    endfunction

    function automatic void push_word(input logic [31:0] w);
        model_apply(w);
        tx_q.push_back(w);
    endfunction

    // Store every register including x0
    function automatic void push_dump();
        for (int i = 0; i < N_DUMP; i++) begin
            push_word(enc_s(12'(i * 4), 5'(i), 5'd0));
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks and per-test report
    //////////////////////////////////////////////////////////////////////
    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
            #1;
        end while (!(tx_q.size() == 0 && exp_q.size() == 0 && held == 0));
    endtask

    task automatic start_test();
        test_errs0 = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        wait_idle();
        check("sender credits at end", tx_credits, riscv_pkg::FETCH_DEPTH);
        if (errors != test_errs0) tests_failed++;
        $display("test %-14s %s (%0d errors)", name,
                 (errors == test_errs0) ? "ok" : "FAILED", errors - test_errs0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sender and receiver driven just after the rising edge
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        #1;
        instr_in    = '0;
        data_credit = 1'b0;
        if (arst_n) begin
            if (tx_credits > 0 && tx_q.size() > 0 && (burst || rand_below(4) != 0)) begin
                instr_in.valid = 1'b1;
                instr_in.instr = tx_q.pop_front();
                tx_credits--;
            end
            if (held > 0 && !hold_credits && rand_below(3) == 0) begin  // Random free delay
                data_credit = 1'b1;
                held--;
            end
        end
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        logic [63:0] e;
        if (arst_n) begin
            if (instr_credit) tx_credits++;
            if (store_out.valid) begin
                rx_count++;
                held++;
                check("receiver occupancy ok", 32'(held <= riscv_pkg::STORE_CREDITS), 32'd1);
                if (exp_q.size() == 0) begin
                    $display("Unexpected store at %0t ns, the model expects none", $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check("store address", store_out.addr, e[63:32]);
                    check("store data", store_out.data, e[31:0]);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [4:0]  prev;
        logic [4:0]  rd;
        logic [6:0]  opc;
        logic [31:0] r;
        int          snap;
        seed         = 32'h47e6;
        instr_in     = '0;
        data_credit  = 1'b0;
        arst_n       = 1'b0;
        burst        = 1'b0;
        hold_credits = 1'b0;
        tx_credits   = riscv_pkg::FETCH_DEPTH;
        held         = 0;
        rx_count     = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;

        // Quiet outputs in and after reset
        start_test();
        repeat (10) begin
            @(negedge clk);
            check("instr_credit in reset", 32'(instr_credit), 32'd0);
            check("store valid in reset", 32'(store_out.valid), 32'd0);
        end
        @(posedge clk);
        #1 arst_n = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check("instr_credit idle", 32'(instr_credit), 32'd0);
            check("store valid idle", 32'(store_out.valid), 32'd0);
        end
        end_test("reset");

        start_test();
        for (int i = 0; i < N_RAND; i++) push_word(random_word());
        push_dump();
        end_test("random");

        // Writes to x0 and stores of x0
        start_test();
        for (int i = 0; i < N_X0; i++) begin
            if (i % 3 == 2) push_word(enc_s(12'(rand_below(4096)), 5'd0, rand_reg()));
            else            push_word(alu_word(5'd0, rand_reg(), rand_reg()));
        end
        push_dump();
        end_test("x0");

        // Each op reads the result just before it
        start_test();
        burst = 1'b1;
        prev  = 5'd1;
        push_word(enc_i(12'(rand_below(4096)), 5'd0, riscv_pkg::F3_ADD, prev));
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = 5'((prev % 7) + 1);
            push_word(alu_word(rd, prev, (rand_below(2) == 1) ? prev : rand_reg()));
            if (i % 3 == 2) push_word(enc_s(12'(rand_below(4096)), rd, prev));
            prev = rd;
        end
        push_dump();
        end_test("forwarding");
        burst = 1'b0;

        // Receiver withholds credits until the pipeline stalls
        start_test();
        hold_credits = 1'b1;
        snap         = rx_count;
        for (int i = 0; i < N_BP; i++) begin
            if (i % 2 == 1) push_word(enc_s(12'(rand_below(4096)), rand_reg(), rand_reg()));
            else            push_word(alu_word(rand_reg(), rand_reg(), rand_reg()));
        end
        push_dump();
        repeat (HOLD_CYCLES) @(negedge clk);
        #1;
        check("stores during hold", 32'(rx_count - snap), riscv_pkg::STORE_CREDITS);
        check("sender stalled", 32'(tx_q.size() > 0), 32'd1);
        check("sender credits while stalled", tx_credits, 32'd0);
        hold_credits = 1'b0;
        end_test("backpressure");

        // Unknown opcodes retire with no effect
        start_test();
        snap = rx_count;
        for (int i = 0; i < N_BAD; i++) begin
            do begin
                opc = 7'(rand_below(128));
            end while (opc == riscv_pkg::OPC_OP || opc == riscv_pkg::OPC_OP_IMM ||
                       opc == riscv_pkg::OPC_STORE);
            r = next_rand();
            push_word({r[31:7], opc});
        end
        push_dump();
        wait_idle();
        check("stores from bad opcodes", 32'(rx_count - snap), N_DUMP);
        end_test("bad_opcode");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/riscv_pkg.sv
logic/instr_buffer.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/exec_stage.sv
logic/store_queue.sv
logic/riscv_core.sv
dv/riscv_core_asserts.sv
dv/riscv_core_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the riscv_core testbench with Verilator, log in sim.log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module riscv_core_tb \
    --Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    echo "Simulation reported failures"
    exit 1
fi
exit 0
